// ==== verilog.f ====
+incdir+verilog
verilog/ctrl_pkg.sv
verilog/instr_decoder.sv
verilog/seq_fsm.sv
verilog/alu_op_decode.sv
verilog/datapath_ctrl.sv
verilog/ctrl_top.sv
dv/tb_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the control unit testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_ctrl -f verilog.f -o sim_ctrl &&
./obj_dir/sim_ctrl | tee /dev/stderr | grep -q "NO ERRORS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== dv/tb_ctrl.sv ====
// Testbench for the RV32I multi-cycle control unit
// Plays datapath and memory, walks a table of instructions through the DUT
// and checks immediates, ALU ops, mux selects, memory size and fetch timing

`timescale 1ns/10ps
`default_nettype none

`include "ctrl_consts.svh"

module tb_ctrl;

  import ctrl_pkg::*;

  typedef struct packed {
    logic [31:0] ir;
    logic [2:0]  bsr;
    logic [31:0] imm;      // Expected immediate
    logic [3:0]  alu;      // alu_op at load_reg
    logic [1:0]  reg_rs1;  // Selects at load_reg
    logic [1:0]  reg_rs2;
    logic [1:0]  pc_rs1;   // Selects at load_pc
    logic [1:0]  pc_rs2;
    logic [1:0]  size;     // At the data strobe
    logic        uns;
    logic [1:0]  nreg;     // Number of load_reg pulses
    logic        nmdr;     // Number of mdr_mux_sel pulses
  } row_t;

  logic clk, rst_n, mem_resp;
  logic [31:0] ir;
  logic [2:0]  bsr;
  logic        load_mar, load_pc, load_ir, load_mdr, load_reg, mdr_mux_sel;
  logic        mem_read, mem_write, load_unsigned;
  rs1_mux_sel_t     rs1_mux_sel;
  rs2_mux_sel_t     rs2_mux_sel;
  databus_mux_sel_t databus_mux_sel;
  alu_op_t          alu_op;
  mem_size_t        mem_size;
  logic [`REG_ADDR_W-1:0] rs1, rs2, rd;
  logic [`XLEN-1:0]       immediate;
  row_t        rows[$];
  int unsigned seed = 65735;
  int          cyc, resp_cyc;
  logic        fetch_wait;

  ctrl_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic int unsigned next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return (seed >> 16) & 32'd3;
  endfunction

  task automatic abort(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("Mismatch %s exp=%h got=%h", name, exp, got);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  // Instruction encoders
  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [6:0] opc);
    return {imm, 5'd2, f3, 5'd1, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic a, input logic [2:0] f3);
    return {1'b0, a, 5'd0, 5'd3, 5'd2, f3, 5'd1, `OPC_ALU};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [2:0] f3);
    return {imm[11:5], 5'd3, 5'd2, f3, imm[4:0], `OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd3, 5'd2, f3, imm[4:1], imm[11], `OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, `OPC_JAL};
  endfunction

  // Register-register funct3 map, arithmetic bit picks SUB and SRA
  function automatic logic [3:0] rr_alu(input logic [2:0] f3, input logic a);
    case (f3)
      3'd0:    return a ? 4'(ALU_SUB) : 4'(ALU_ADD);
      3'd1:    return 4'(ALU_SLL);
      3'd2:    return 4'(ALU_SLT);
      3'd3:    return 4'(ALU_SLTU);
      3'd4:    return 4'(ALU_XOR);
      3'd5:    return a ? 4'(ALU_SRA) : 4'(ALU_SRL);
      3'd6:    return 4'(ALU_OR);
      default: return 4'(ALU_AND);
    endcase
  endfunction

  task automatic add_row(input logic [31:0] ir_v, input logic [2:0] bsr_v,
                         input logic [31:0] imm, input logic [3:0] alu,
                         input logic [1:0] r1, input logic [1:0] r2,
                         input logic [1:0] p1, input logic [1:0] p2,
                         input logic [1:0] size, input logic uns,
                         input logic [1:0] nreg, input logic nmdr);
    row_t r;
    r = '{ir_v, bsr_v, imm, alu, r1, r2, p1, p2, size, uns, nreg, nmdr};
    rows.push_back(r);
  endtask

  task automatic build_table();
    logic [11:0] ai;
    for (int f = 0; f < 8; f++) begin
      for (int a = 0; a < 2; a++) begin
        ai = {1'b0, a[0], 10'h013};
        add_row(enc_r(a[0], 3'(f)), 3'b0, 32'h0, rr_alu(3'(f), a[0]), RS1_OUT, RS2_OUT,
                RS1_4, RS2_PC, MEM_WORD, 1'b0, 2'd1, 1'b0);
        add_row(enc_i(ai, 3'(f), `OPC_ALUI), 3'b0, {20'h0, ai},
                (f == 0) ? 4'(ALU_ADD) : rr_alu(3'(f), a[0]), RS1_OUT, RS2_IMM,
                RS1_4, RS2_PC, MEM_WORD, 1'b0, 2'd1, 1'b0);
      end
    end
    add_row({20'hABCDE, 5'd1, `OPC_LUI}, 3'b0, 32'hABCDE000, ALU_PASS_RS2, RS1_OUT,
            RS2_IMM, RS1_4, RS2_PC, MEM_WORD, 1'b0, 2'd1, 1'b0);
    add_row({20'h80001, 5'd1, `OPC_AUIPC}, 3'b0, 32'h80001000, ALU_ADD, RS1_PC,
            RS2_IMM, RS1_4, RS2_PC, MEM_WORD, 1'b0, 2'd1, 1'b0);
    // Branches, taken then not taken; bsr is {eq, lt, ltu}
    add_row(enc_b(13'h1FF0, `F3_BEQ), 3'b100, 32'hFFFFFFF0, ALU_ADD, RS1_OUT, RS2_OUT,
            RS1_PC, RS2_IMM, MEM_WORD, 1'b0, 2'd0, 1'b0);
    add_row(enc_b(13'h1FF0, `F3_BEQ), 3'b000, 32'hFFFFFFF0, ALU_ADD, RS1_OUT, RS2_OUT,
            RS1_4, RS2_PC, MEM_WORD, 1'b0, 2'd0, 1'b0);
    add_row(enc_b(13'h0010, `F3_BNE), 3'b000, 32'h10, ALU_ADD, RS1_OUT, RS2_OUT,
            RS1_PC, RS2_IMM, MEM_WORD, 1'b0, 2'd0, 1'b0);
    add_row(enc_b(13'h0010, `F3_BNE), 3'b100, 32'h10, ALU_ADD, RS1_OUT, RS2_OUT,
            RS1_4, RS2_PC, MEM_WORD, 1'b0, 2'd0, 1'b0);
    add_row(enc_b(13'h0010, `F3_BLT), 3'b010, 32'h10, ALU_ADD, RS1_OUT, RS2_OUT,
            RS1_PC, RS2_IMM, MEM_WORD, 1'b0, 2'd0, 1'b0);
    add_row(enc_b(13'h0010, `F3_BLT), 3'b101, 32'h10, ALU_ADD, RS1_OUT, RS2_OUT,
            RS1_4, RS2_PC, MEM_WORD, 1'b0, 2'd0, 1'b0);
    add_row(enc_b(13'h0010, `F3_BGE), 3'b000, 32'h10, ALU_ADD, RS1_OUT, RS2_OUT,
            RS1_PC, RS2_IMM, MEM_WORD, 1'b0, 2'd0, 1'b0);
    add_row(enc_b(13'h0010, `F3_BGE), 3'b010, 32'h10, ALU_ADD, RS1_OUT, RS2_OUT,
            RS1_4, RS2_PC, MEM_WORD, 1'b0, 2'd0, 1'b0);
    add_row(enc_b(13'h0010, `F3_BLTU), 3'b001, 32'h10, ALU_ADD, RS1_OUT, RS2_OUT,
            RS1_PC, RS2_IMM, MEM_WORD, 1'b0, 2'd0, 1'b0);
    add_row(enc_b(13'h0010, `F3_BLTU), 3'b110, 32'h10, ALU_ADD, RS1_OUT, RS2_OUT,
            RS1_4, RS2_PC, MEM_WORD, 1'b0, 2'd0, 1'b0);
    add_row(enc_b(13'h0010, `F3_BGEU), 3'b000, 32'h10, ALU_ADD, RS1_OUT, RS2_OUT,
            RS1_PC, RS2_IMM, MEM_WORD, 1'b0, 2'd0, 1'b0);
    add_row(enc_b(13'h0010, `F3_BGEU), 3'b001, 32'h10, ALU_ADD, RS1_OUT, RS2_OUT,
            RS1_4, RS2_PC, MEM_WORD, 1'b0, 2'd0, 1'b0);
    // Jumps
    add_row(enc_j(21'h000800), 3'b0, 32'h800, ALU_ADD, RS1_4, RS2_PC, RS1_PC, RS2_IMM,
            MEM_WORD, 1'b0, 2'd1, 1'b0);
    add_row(enc_i(12'h004, 3'd0, `OPC_JALR), 3'b0, 32'h4, ALU_ADD, RS1_4, RS2_PC,
            RS1_OUT, RS2_IMM, MEM_WORD, 1'b0, 2'd1, 1'b0);
    // Loads, one negative offset
    add_row(enc_i(12'hFF8, `F3_BYTE, `OPC_LOAD), 3'b0, 32'hFFFFFFF8, ALU_ADD, RS1_OUT,
            RS2_OUT, RS1_4, RS2_PC, MEM_BYTE, 1'b0, 2'd1, 1'b0);
    add_row(enc_i(12'h008, `F3_HALF, `OPC_LOAD), 3'b0, 32'h8, ALU_ADD, RS1_OUT,
            RS2_OUT, RS1_4, RS2_PC, MEM_HALF, 1'b0, 2'd1, 1'b0);
    add_row(enc_i(12'h008, `F3_WORD, `OPC_LOAD), 3'b0, 32'h8, ALU_ADD, RS1_OUT,
            RS2_OUT, RS1_4, RS2_PC, MEM_WORD, 1'b0, 2'd1, 1'b0);
    add_row(enc_i(12'h008, `F3_BYTE_U, `OPC_LOAD), 3'b0, 32'h8, ALU_ADD, RS1_OUT,
            RS2_OUT, RS1_4, RS2_PC, MEM_BYTE, 1'b1, 2'd1, 1'b0);
    add_row(enc_i(12'h008, `F3_HALF_U, `OPC_LOAD), 3'b0, 32'h8, ALU_ADD, RS1_OUT,
            RS2_OUT, RS1_4, RS2_PC, MEM_HALF, 1'b1, 2'd1, 1'b0);
    // Stores
    add_row(enc_s(12'h804, `F3_BYTE), 3'b0, 32'hFFFFF804, ALU_ADD, RS1_OUT, RS2_OUT,
            RS1_4, RS2_PC, MEM_BYTE, 1'b0, 2'd0, 1'b1);
    add_row(enc_s(12'h024, `F3_HALF), 3'b0, 32'h24, ALU_ADD, RS1_OUT, RS2_OUT,
            RS1_4, RS2_PC, MEM_HALF, 1'b0, 2'd0, 1'b1);
    add_row(enc_s(12'h024, `F3_WORD), 3'b0, 32'h24, ALU_ADD, RS1_OUT, RS2_OUT,
            RS1_4, RS2_PC, MEM_WORD, 1'b0, 2'd0, 1'b1);
  endtask

  // Memory responder, answers each strobe after 0 to 3 extra wait cycles
  initial begin
    int unsigned d;
    mem_resp = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && (mem_read || mem_write)) begin
        d = next_rand();
        @(posedge clk);
        #1;
        repeat (d) begin
          @(posedge clk);
          #1;
        end
        mem_resp = 1'b1;
        @(posedge clk);
        #1 mem_resp = 1'b0;
      end
    end
  end

  // One cycle, sampled mid-cycle; also tracks fetch timing
  task automatic sample();
    @(negedge clk);
    cyc++;
    if (fetch_wait && mem_resp) begin
      resp_cyc   = cyc;
      fetch_wait = 1'b0;
    end
    if (load_ir) begin
      check("load_ir delay", 32'd2, 32'(cyc - resp_cyc));
      check("databus_mux_sel at load_ir", 32'(DATABUS_MDR), 32'(databus_mux_sel));
    end
  endtask

  function automatic logic fetch_start();
    return load_mar && mem_read;
  endfunction

  // Load enables and memory strobes as one vector
  function automatic logic [7:0] strobes();
    return {load_mar, load_pc, load_ir, load_mdr, load_reg, mdr_mux_sel, mem_read,
            mem_write};
  endfunction

  task automatic do_reset();
    @(posedge clk);
    #1 rst_n = 1'b0;
    repeat (3) @(posedge clk);
    sample();
    check("strobes in reset", 32'd0, 32'(strobes()));
    @(posedge clk);
    #1 rst_n = 1'b1;
    sample();
    check("load_mar", 32'd1, 32'(load_mar));
    check("mem_read", 32'd1, 32'(mem_read));
    fetch_wait = 1'b1;
  endtask

  task automatic run_row(input row_t r);
    int   n;
    int   nreg;
    int   nmdr;
    int   nld;
    int   npc;
    logic first;
    logic is_load;
    logic is_mem;
    n       = 0;
    nreg    = 0;
    nmdr    = 0;
    nld     = 0;
    npc     = 0;
    first   = 1'b1;
    is_load = (r.ir[6:0] == `OPC_LOAD);
    is_mem  = is_load || (r.ir[6:0] == `OPC_STORE);
    @(posedge clk);
    #1;
    ir  = r.ir;
    bsr = r.bsr;
    forever begin
      sample();
      n++;
      if (n > 60) abort("Timeout waiting for the next instruction fetch");
      if (first) check("immediate", r.imm, immediate);
      if (first && r.ir[6:0] == `OPC_ALU) begin  // Register numbers from enc_r
        check("rd", 32'd1, 32'(rd));
        check("rs1", 32'd2, 32'(rs1));
        check("rs2", 32'd3, 32'(rs2));
      end
      first = 1'b0;
      if (fetch_start()) begin
        check("mem_size at fetch", 32'(MEM_WORD), 32'(mem_size));
        break;
      end
      if (load_reg) begin
        nreg++;
        check("alu_op", 32'(r.alu), 32'(alu_op));
        check("rs1_mux_sel at load_reg", 32'(r.reg_rs1), 32'(rs1_mux_sel));
        check("rs2_mux_sel at load_reg", 32'(r.reg_rs2), 32'(rs2_mux_sel));
        check("databus_mux_sel at load_reg",
              is_load ? 32'(DATABUS_MDR) : 32'(DATABUS_ALU), 32'(databus_mux_sel));
      end
      if (load_pc) begin
        npc++;
        check("rs1_mux_sel at load_pc", 32'(r.pc_rs1), 32'(rs1_mux_sel));
        check("rs2_mux_sel at load_pc", 32'(r.pc_rs2), 32'(rs2_mux_sel));
      end
      if (mem_read || mem_write) begin  // Data access strobe
        check("mem_size", 32'(r.size), 32'(mem_size));
        check("load_unsigned", 32'(r.uns), 32'(load_unsigned));
      end
      if (load_mdr) nld++;
      if (mdr_mux_sel) begin
        nmdr++;
        check("alu_op with mdr_mux_sel", 32'(ALU_PASS_RS2), 32'(alu_op));
        check("load_mdr with mdr_mux_sel", 32'd1, 32'(load_mdr));
      end
    end
    check("load_reg pulses", 32'(r.nreg), 32'(nreg));
    check("mdr_mux_sel pulses", 32'(r.nmdr), 32'(nmdr));
    check("load_mdr pulses", is_mem ? 32'd2 : 32'd1, 32'(nld));  // Fetch plus data
    check("load_pc pulses", 32'd1, 32'(npc));
    fetch_wait = 1'b1;
  endtask

  // Error opcodes halt, nothing may strobe after the fetch
  task automatic run_halt(input logic [31:0] ir_v);
    int n;
    n = 0;
    @(posedge clk);
    #1 ir = ir_v;
    while (!load_ir) begin
      sample();
      n++;
      if (n > 20) abort("Timeout waiting for load_ir before halt");
    end
    repeat (20) begin
      sample();
      check("strobes in halt", 32'd0, 32'(strobes()));
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    ir         = 32'h0;
    bsr        = 3'b0;
    cyc        = 0;
    resp_cyc   = 0;
    fetch_wait = 1'b0;
    build_table();
    do_reset();
    foreach (rows[i]) run_row(rows[i]);
    run_halt(32'h0000007F);  // Undefined opcode
    do_reset();
    run_halt({25'h0, `OPC_FENCE});
    $display("NO ERRORS");
    $finish;
  end

  // Overall limit on run time
  initial begin
    #500us;
    abort("Simulation ran past its time limit");
  end

endmodule

`default_nettype wire

// ==== verilog/ctrl_top.sv ====
// RV32I multi-cycle control unit
// Connects the instruction decoder, the sequencing FSM, the ALU operation
// decoder and the datapath strobe decoder

`timescale 1ns/10ps
`default_nettype none

`include "ctrl_consts.svh"

module ctrl_top (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic [`XLEN-1:0]       ir,
  input  wire logic [2:0]             bsr,
  input  wire logic                   mem_resp,
  output logic                        load_mar,
  output logic                        load_pc,
  output logic                        load_ir,
  output logic                        load_mdr,
  output logic                        load_reg,
  output logic                        mdr_mux_sel,
  output ctrl_pkg::rs1_mux_sel_t      rs1_mux_sel,
  output ctrl_pkg::rs2_mux_sel_t      rs2_mux_sel,
  output ctrl_pkg::databus_mux_sel_t  databus_mux_sel,
  output ctrl_pkg::alu_op_t           alu_op,
  output logic                        mem_read,
  output logic                        mem_write,
  output ctrl_pkg::mem_size_t         mem_size,
  output logic                        load_unsigned,
  output logic      [`REG_ADDR_W-1:0] rs1,
  output logic      [`REG_ADDR_W-1:0] rs2,
  output logic      [`REG_ADDR_W-1:0] rd,
  output logic      [`XLEN-1:0]       immediate
);

  import ctrl_pkg::*;

  logic [`OPC_W-1:0] opcode;
  logic [`F3_W-1:0]  funct3;
  logic              arithmetic;  // ir[30]
  state_t            state;

  instr_decoder u_instr_decoder (
    .ir         (ir),
    .opcode     (opcode),
    .funct3     (funct3),
    .arithmetic (arithmetic),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .immediate  (immediate)
  );

  seq_fsm u_seq_fsm (
    .clk      (clk),
    .rst_n    (rst_n),
    .opcode   (opcode),
    .funct3   (funct3),
    .bsr      (bsr),
    .mem_resp (mem_resp),
    .state    (state)
  );

  alu_op_decode u_alu_op_decode (
    .state      (state),
    .funct3     (funct3),
    .arithmetic (arithmetic),
    .alu_op     (alu_op)
  );

  datapath_ctrl u_datapath_ctrl (
    .rst_n           (rst_n),
    .state           (state),
    .opcode          (opcode),
    .funct3          (funct3),
    .load_mar        (load_mar),
    .load_pc         (load_pc),
    .load_ir         (load_ir),
    .load_mdr        (load_mdr),
    .load_reg        (load_reg),
    .mdr_mux_sel     (mdr_mux_sel),
    .rs1_mux_sel     (rs1_mux_sel),
    .rs2_mux_sel     (rs2_mux_sel),
    .databus_mux_sel (databus_mux_sel),
    .mem_read        (mem_read),
    .mem_write       (mem_write),
    .mem_size        (mem_size),
    .load_unsigned   (load_unsigned)
  );

endmodule

`default_nettype wire

// ==== verilog/datapath_ctrl.sv ====
// Datapath strobe decoder
// Drives register load enables, mux selects and memory strobes per state,
// plus the access width and unsigned flag for loads and stores
// Fetch always uses a word access

`timescale 1ns/10ps
`default_nettype none

`include "ctrl_consts.svh"

module datapath_ctrl (
  input  wire logic                rst_n,
  input  ctrl_pkg::state_t         state,
  input  wire logic [`OPC_W-1:0]   opcode,
  input  wire logic [`F3_W-1:0]    funct3,
  output logic                     load_mar,
  output logic                     load_pc,
  output logic                     load_ir,
  output logic                     load_mdr,
  output logic                     load_reg,
  output logic                     mdr_mux_sel,   // MDR from databus, not memory
  output ctrl_pkg::rs1_mux_sel_t   rs1_mux_sel,
  output ctrl_pkg::rs2_mux_sel_t   rs2_mux_sel,
  output ctrl_pkg::databus_mux_sel_t databus_mux_sel,
  output logic                     mem_read,
  output logic                     mem_write,
  output ctrl_pkg::mem_size_t      mem_size,
  output logic                     load_unsigned
);

  import ctrl_pkg::*;

  always_comb begin
    load_mar        = 1'b0;
    load_pc         = 1'b0;
    load_ir         = 1'b0;
    load_mdr        = 1'b0;
    load_reg        = 1'b0;
    mdr_mux_sel     = 1'b0;
    rs1_mux_sel     = RS1_OUT;
    rs2_mux_sel     = RS2_OUT;
    databus_mux_sel = DATABUS_ALU;  // ALU drives the bus in most states
    mem_read        = 1'b0;
    mem_write       = 1'b0;
    if (rst_n) begin  // Strobes held low during reset
      case (state)
        FETCH_0: begin
          load_mar        = 1'b1;
          mem_read        = 1'b1;
          databus_mux_sel = DATABUS_PC;
        end
        FETCH_2: load_mdr = 1'b1;
        FETCH_3: begin
          load_ir         = 1'b1;
          databus_mux_sel = DATABUS_MDR;
        end
        BRANCH_T, JAL_1: begin  // PC <- PC + imm
          load_pc     = 1'b1;
          rs1_mux_sel = RS1_PC;
          rs2_mux_sel = RS2_IMM;
        end
        PC_INC: begin  // PC <- 4 + PC
          load_pc     = 1'b1;
          rs1_mux_sel = RS1_4;
          rs2_mux_sel = RS2_PC;
        end
        JAL_0, JALR_0: begin  // Return address
          load_reg    = 1'b1;
          rs1_mux_sel = RS1_4;
          rs2_mux_sel = RS2_PC;
        end
        JALR_1: begin
          load_pc     = 1'b1;
          rs2_mux_sel = RS2_IMM;  // rs1 + imm
        end
        REG_REG: load_reg = 1'b1;
        REG_IMM, LUI_0: begin
          load_reg    = 1'b1;
          rs2_mux_sel = RS2_IMM;
        end
        AUIPC_0: begin
          load_reg    = 1'b1;
          rs1_mux_sel = RS1_PC;
          rs2_mux_sel = RS2_IMM;
        end
        LD_0, ST_0: begin  // Effective address into MAR
          load_mar    = 1'b1;
          rs2_mux_sel = RS2_IMM;
        end
        LD_1: mem_read = 1'b1;
        LD_3: load_mdr = 1'b1;
        LD_4: begin
          load_reg        = 1'b1;
          databus_mux_sel = DATABUS_MDR;
        end
        ST_1: begin  // Store data via ALU pass-through
          load_mdr    = 1'b1;
          mdr_mux_sel = 1'b1;
        end
        ST_2: mem_write = 1'b1;
        default: ;  // Wait, decode and error states drive nothing
      endcase
    end
  end

  // Access width and sign handling
  always_comb begin
    mem_size      = MEM_WORD;
    load_unsigned = 1'b0;
    if (!(state inside {FETCH_0, FETCH_1, FETCH_2, FETCH_3}) &&
        (opcode == `OPC_LOAD || opcode == `OPC_STORE)) begin
      case (funct3)
        `F3_BYTE, `F3_BYTE_U: mem_size = MEM_BYTE;
        `F3_HALF, `F3_HALF_U: mem_size = MEM_HALF;
        default:              mem_size = MEM_WORD;
      endcase
      // Unsigned flag only matters for loads
      load_unsigned = (opcode == `OPC_LOAD) &&
                      (funct3 == `F3_BYTE_U || funct3 == `F3_HALF_U);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/alu_op_decode.sv ====
// ALU operation decoder
// Picks the ALU function for the current state, from funct3 and the
// arithmetic bit in the register-register and register-immediate states

`timescale 1ns/10ps
`default_nettype none

module alu_op_decode (
  input  ctrl_pkg::state_t  state,
  input  wire logic [2:0]   funct3,
  input  wire logic         arithmetic,
  output ctrl_pkg::alu_op_t alu_op
);

  import ctrl_pkg::*;

  alu_op_t f3_op;  // funct3 map shared by both ALU states

  always_comb begin
    case (funct3)
      3'b000:  f3_op = arithmetic ? ALU_SUB : ALU_ADD;
      3'b001:  f3_op = ALU_SLL;
      3'b010:  f3_op = ALU_SLT;
      3'b011:  f3_op = ALU_SLTU;
      3'b100:  f3_op = ALU_XOR;
      3'b101:  f3_op = arithmetic ? ALU_SRA : ALU_SRL;
      3'b110:  f3_op = ALU_OR;
      default: f3_op = ALU_AND;
    endcase
  end

  always_comb begin
    case (state)
      REG_REG: alu_op = f3_op;
      // ADDI has no SUB form, bit 30 is part of the immediate
      REG_IMM: alu_op = (funct3 == 3'b000) ? ALU_ADD : f3_op;
      LUI_0,
      ST_1:    alu_op = ALU_PASS_RS2;  // Immediate or store data straight through
      default: alu_op = ALU_ADD;       // Address and PC arithmetic
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/seq_fsm.sv ====
// Sequencing FSM of the multi-cycle control unit
// Four-cycle fetch, decode and dispatch, per-class execution sequences
// and the branch decision from the comparator flags
// Error states halt until reset

`timescale 1ns/10ps
`default_nettype none

`include "ctrl_consts.svh"

module seq_fsm (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic [`OPC_W-1:0] opcode,
  input  wire logic [`F3_W-1:0]  funct3,
  input  wire logic [2:0]        bsr,       // {eq, lt, ltu}
  input  wire logic              mem_resp,
  output ctrl_pkg::state_t       state
);

  import ctrl_pkg::*;

  state_t next_state;
  logic   taken;

  always_ff @(posedge clk) begin
    if (!rst_n) state <= FETCH_0;
    else        state <= next_state;
  end

  // Branch condition from comparator flags
  always_comb begin
    case (funct3)
      `F3_BEQ:  taken = bsr[2];
      `F3_BNE:  taken = !bsr[2];
      `F3_BLT:  taken = bsr[1];
      `F3_BGE:  taken = !bsr[1];
      `F3_BLTU: taken = bsr[0];
      `F3_BGEU: taken = !bsr[0];
      default:  taken = 1'b0;  // Reserved funct3 falls through to PC + 4
    endcase
  end

  always_comb begin
    next_state = FETCH_0;  // Most sequences end back at fetch
    case (state)
      FETCH_0:  next_state = FETCH_1;
      FETCH_1:  next_state = mem_resp ? FETCH_2 : FETCH_1;
      FETCH_2:  next_state = FETCH_3;
      FETCH_3:  next_state = DECODE;
      DECODE: begin
        case (opcode)
          `OPC_LUI:    next_state = LUI_0;
          `OPC_AUIPC:  next_state = AUIPC_0;
          `OPC_JAL:    next_state = JAL_0;
          `OPC_JALR:   next_state = JALR_0;
          `OPC_BRANCH: next_state = BRANCH_0;
          `OPC_LOAD:   next_state = LD_0;
          `OPC_STORE:  next_state = ST_0;
          `OPC_ALUI:   next_state = REG_IMM;
          `OPC_ALU:    next_state = REG_REG;
          `OPC_FENCE,
          `OPC_SYSTEM: next_state = ERR_UNIMPL;
          default:     next_state = ERR_INVALID;
        endcase
      end
      BRANCH_0: next_state = taken ? BRANCH_T : PC_INC;
      JAL_0:    next_state = JAL_1;
      JALR_0:   next_state = JALR_1;
      // Single-cycle ALU classes write rd, then advance PC
      REG_REG,
      REG_IMM,
      LUI_0,
      AUIPC_0:  next_state = PC_INC;
      LD_0:     next_state = LD_1;
      LD_1:     next_state = LD_2;
      LD_2:     next_state = mem_resp ? LD_3 : LD_2;
      LD_3:     next_state = LD_4;
      LD_4:     next_state = PC_INC;
      ST_0:     next_state = ST_1;
      ST_1:     next_state = ST_2;
      ST_2:     next_state = ST_3;
      ST_3:     next_state = mem_resp ? PC_INC : ST_3;
      ERR_INVALID: next_state = ERR_INVALID;  // Halt
      ERR_UNIMPL:  next_state = ERR_UNIMPL;   // Halt
      default:  next_state = FETCH_0;  // BRANCH_T, PC_INC, JAL_1, JALR_1
    endcase
  end

  // An error state is only left through reset
  a_err_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state inside {ERR_INVALID, ERR_UNIMPL}) |=> $stable(state)
  ) else $error("FSM left error state %s", state.name());

endmodule

`default_nettype wire

// ==== verilog/instr_decoder.sv ====
// Instruction field decoder
// Slices the RV32I instruction word into its fields and builds the
// sign-extended immediate for the I, S, B, U and J formats

`timescale 1ns/10ps
`default_nettype none

`include "ctrl_consts.svh"

module instr_decoder (
  input  wire logic [`XLEN-1:0]       ir,
  output logic      [`OPC_W-1:0]      opcode,
  output logic      [`F3_W-1:0]       funct3,
  output logic                        arithmetic,
  output logic      [`REG_ADDR_W-1:0] rs1,
  output logic      [`REG_ADDR_W-1:0] rs2,
  output logic      [`REG_ADDR_W-1:0] rd,
  output logic      [`XLEN-1:0]       immediate
);

  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;

  // Fixed field positions
  assign opcode     = ir[6:0];
  assign rd         = ir[11:7];
  assign funct3     = ir[14:12];
  assign rs1        = ir[19:15];
  assign rs2        = ir[24:20];
  assign arithmetic = ir[30];  // SUB and SRA/SRAI select

  // Immediate formats, all sign-extended from ir[31]
  assign imm_i = {{(`XLEN-12){ir[31]}}, ir[31:20]};
  assign imm_s = {{(`XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{(`XLEN-13){ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_u = {ir[31:12], 12'b0};  // Upper 20 bits, no extension needed
  assign imm_j = {{(`XLEN-21){ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

  // Format chosen by opcode
  always_comb begin
    case (opcode)
      `OPC_JALR,
      `OPC_LOAD,
      `OPC_ALUI:   immediate = imm_i;
      `OPC_STORE:  immediate = imm_s;
      `OPC_BRANCH: immediate = imm_b;
      `OPC_LUI,
      `OPC_AUIPC:  immediate = imm_u;
      `OPC_JAL:    immediate = imm_j;
      default:     immediate = '0;  // R-type and unsupported opcodes
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/ctrl_pkg.sv ====
// RV32I control unit types
// FSM states, ALU operations, datapath mux selects and memory access size

`default_nettype none

`include "ctrl_consts.svh"

package ctrl_pkg;

  // Sequencer states
  typedef enum logic [`STATE_W-1:0] {
    FETCH_0,      // MAR <- PC, start read
    FETCH_1,      // Wait on memory
    FETCH_2,      // MDR <- memory
    FETCH_3,      // IR <- MDR
    DECODE,       // Dispatch on opcode
    BRANCH_0,     // Evaluate condition
    BRANCH_T,     // PC <- PC + imm
    PC_INC,       // PC <- PC + 4
    JAL_0,        // rd <- PC + 4
    JAL_1,        // PC <- PC + imm
    REG_REG,
    REG_IMM,
    LUI_0,
    AUIPC_0,
    JALR_0,       // rd <- PC + 4
    JALR_1,       // PC <- rs1 + imm
    LD_0,         // MAR <- rs1 + imm
    LD_1,         // Start read
    LD_2,         // Wait on memory
    LD_3,         // MDR <- memory
    LD_4,         // rd <- MDR
    ST_0,         // MAR <- rs1 + imm
    ST_1,         // MDR <- rs2
    ST_2,         // Start write
    ST_3,         // Wait on memory
    ERR_INVALID,  // Undefined opcode, halts
    ERR_UNIMPL    // FENCE or SYSTEM, halts
  } state_t;

  typedef enum logic [`ALU_OP_W-1:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_RS1, ALU_PASS_RS2
  } alu_op_t;

  // ALU A input
  typedef enum logic [`SEL_W-1:0] {RS1_OUT, RS1_PC, RS1_4} rs1_mux_sel_t;

  // ALU B input
  typedef enum logic [`SEL_W-1:0] {RS2_OUT, RS2_IMM, RS2_PC} rs2_mux_sel_t;

  // Source driving the internal databus
  typedef enum logic [`SEL_W-1:0] {DATABUS_PC, DATABUS_ALU, DATABUS_MDR} databus_mux_sel_t;

  typedef enum logic [`SEL_W-1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_t;

endpackage

`default_nettype wire

// ==== verilog/ctrl_consts.svh ====
// RV32I control unit constants
// Widths, major opcodes and funct3 codes shared by the control blocks
// and the testbench

`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

// Widths
`define XLEN        32  // Data and instruction word
`define REG_ADDR_W  5   // Register index
`define OPC_W       7   // Major opcode field
`define F3_W        3   // funct3 field
`define STATE_W     5   // FSM state encoding
`define ALU_OP_W    4   // ALU operation encoding
`define SEL_W       2   // Mux selects and access size

// Major opcodes, ir[6:0]
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_ALUI    7'b0010011
`define OPC_ALU     7'b0110011
`define OPC_FENCE   7'b0001111
`define OPC_SYSTEM  7'b1110011

// Branch conditions
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

// Load and store widths
`define F3_BYTE     3'b000
`define F3_HALF     3'b001
`define F3_WORD     3'b010
`define F3_BYTE_U   3'b100
`define F3_HALF_U   3'b101

`endif
